// ==== build.f ====
common/xlate_pkg.sv
common/tlb_pkg.sv
design/dmw_classify.sv
design/req_fifo.sv
tlb/tlb_array.sv
tlb/tlb_check.sv
design/xlate_top.sv
tests/xlate_checker.sv
tests/xlate_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module xlate_tb -f build.f -o xlate_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/xlate_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== tests/xlate_tb.sv ====
`timescale 1ns/1ps

module xlate_tb;

    localparam int n_rows    = 16;
    localparam int wd_cycles = n_rows * 40 + 200;

    logic                              clk;
    logic                              reset;
    logic                              req_valid;
    logic                              req_ready;
    logic [xlate_pkg::addr_w-1:0]      req_vaddr;
    logic                              req_store;
    logic                              resp_valid;
    logic                              resp_ready;
    logic                              resp_fault;
    xlate_pkg::xlate_result_u          resp_word;
    logic                              cfg_da;
    logic [tlb_pkg::plv_w-1:0]         cfg_plv;
    logic [tlb_pkg::asid_w-1:0]        cfg_asid;
    logic [xlate_pkg::addr_w-1:0]      cfg_dmw0;
    logic [xlate_pkg::addr_w-1:0]      cfg_dmw1;
    logic                              tlb_we;
    logic [tlb_pkg::tlb_idx_w-1:0]     tlb_windex;
    logic                              tlb_we_e;
    logic [tlb_pkg::vpn_w-1:0]         tlb_wvpn;
    logic [tlb_pkg::asid_w-1:0]        tlb_wasid;
    logic                              tlb_wg;
    logic [tlb_pkg::ppn_w-1:0]         tlb_wppn;
    logic [tlb_pkg::plv_w-1:0]         tlb_wplv;
    logic                              tlb_wd;
    logic                              tlb_wv;

    int                                exp_row;
    logic [xlate_pkg::addr_w-1:0]      exp_vaddr;
    logic                              exp_fault;
    logic [xlate_pkg::addr_w-1:0]      exp_word;
    int                                pass_count;
    int                                fail_count;
    int                                pending;
    int                                tb_errors;
    integer                            seed = 4;

    // stimulus table
    logic                              row_da    [n_rows];
    logic [xlate_pkg::addr_w-1:0]      row_vaddr [n_rows];
    logic                              row_store [n_rows];
    logic                              row_fault [n_rows];
    logic [xlate_pkg::addr_w-1:0]      row_word  [n_rows];

    xlate_top xlate_top_i (.*);

    xlate_checker xlate_checker_i (.*);

    function automatic logic [xlate_pkg::addr_w-1:0] fault_word(
            input logic [xlate_pkg::ecode_w-1:0] code);
        return {code, {(xlate_pkg::addr_w - xlate_pkg::ecode_w){1'b0}}};
    endfunction

    task automatic set_row(input int i, input logic da, input logic [31:0] va,
                           input logic st, input logic flt, input logic [31:0] word);
        row_da[i]    = da;
        row_vaddr[i] = va;
        row_store[i] = st;
        row_fault[i] = flt;
        row_word[i]  = word;
    endtask

    task automatic load_entry(input int idx, input logic [19:0] vpn, input logic [9:0] asid,
                              input logic g, input logic [19:0] ppn, input logic [1:0] plv,
                              input logic d, input logic v);
        tlb_we     = 1'b1;
        tlb_windex = idx[tlb_pkg::tlb_idx_w-1:0];
        tlb_we_e   = 1'b1;
        tlb_wvpn   = vpn;
        tlb_wasid  = asid;
        tlb_wg     = g;
        tlb_wppn   = ppn;
        tlb_wplv   = plv;
        tlb_wd     = d;
        tlb_wv     = v;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    // holds the request until the edge that takes it and returns on the next falling edge
    task automatic apply_row(input int i);
        logic took;
        req_valid = 1'b1;
        req_vaddr = row_vaddr[i];
        req_store = row_store[i];
        exp_row   = i;
        exp_vaddr = row_vaddr[i];
        exp_fault = row_fault[i];
        exp_word  = row_word[i];
        took = 1'b0;
        while (!took) begin
            took = req_ready;
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        resp_ready = 1'b0;
        @(negedge clk);
        forever begin
            @(negedge clk);
            resp_ready = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int i;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_store  = 1'b0;
        cfg_da     = 1'b1;
        cfg_plv    = 2'd0;
        cfg_asid   = '0;
        cfg_dmw0   = '0;
        cfg_dmw1   = '0;
        tlb_we     = 1'b0;
        tlb_windex = '0;
        tlb_we_e   = 1'b0;
        tlb_wvpn   = '0;
        tlb_wasid  = '0;
        tlb_wg     = 1'b0;
        tlb_wppn   = '0;
        tlb_wplv   = '0;
        tlb_wd     = 1'b0;
        tlb_wv     = 1'b0;
        exp_row    = 0;
        exp_vaddr  = '0;
        exp_fault  = 1'b0;
        exp_word   = '0;
        tb_errors  = 0;

        // DA mode passes every address through
        set_row(0,  1'b1, 32'h1234_5678, 1'b0, 1'b0, 32'h1234_5678);
        set_row(1,  1'b1, 32'hA000_0010, 1'b1, 1'b0, 32'hA000_0010);
        set_row(2,  1'b1, 32'h8000_1FFC, 1'b0, 1'b0, 32'h8000_1FFC);
        set_row(3,  1'b1, 32'hFFFF_F000, 1'b1, 1'b0, 32'hFFFF_F000);
        // segment 5 through dmw1 and segment 4 missing dmw0 at plv 3
        set_row(4,  1'b0, 32'hA012_3456, 1'b0, 1'b0, 32'h0012_3456);
        set_row(5,  1'b0, 32'hBFFF_F004, 1'b1, 1'b0, 32'h1FFF_F004);
        set_row(6,  1'b0, 32'h8000_3000, 1'b0, 1'b1, fault_word(xlate_pkg::ecode_tlbr));
        // tlb hits and misses by asid
        set_row(7,  1'b0, 32'h0001_0ABC, 1'b0, 1'b0, 32'h1234_0ABC);
        set_row(8,  1'b0, 32'h0001_0004, 1'b1, 1'b0, 32'h1234_0004);
        set_row(9,  1'b0, 32'h0002_0123, 1'b1, 1'b0, 32'h5555_5123);
        set_row(10, 1'b0, 32'h0003_0004, 1'b0, 1'b1, fault_word(xlate_pkg::ecode_tlbr));
        // fault rules
        set_row(11, 1'b0, 32'h0004_0010, 1'b0, 1'b1, fault_word(xlate_pkg::ecode_pil));
        set_row(12, 1'b0, 32'h0004_0020, 1'b1, 1'b1, fault_word(xlate_pkg::ecode_pis));
        set_row(13, 1'b0, 32'h0005_0000, 1'b0, 1'b1, fault_word(xlate_pkg::ecode_ppi));
        set_row(14, 1'b0, 32'h0006_0FF0, 1'b1, 1'b1, fault_word(xlate_pkg::ecode_pme));
        set_row(15, 1'b0, 32'h0006_0FF0, 1'b0, 1'b0, 32'h0ABC_DFF0);

        repeat (4) @(negedge clk);
        reset = 1'b0;
        if (resp_valid !== 1'b0 || req_ready !== 1'b1) begin
            $display("Fail at %0d ns: after reset resp_valid %b req_ready %b",
                     $time, resp_valid, req_ready);
            tb_errors = tb_errors + 1;
        end

        load_entry(0, 20'h00010, 10'd9, 1'b1, 20'h12340, 2'd3, 1'b1, 1'b1);
        load_entry(1, 20'h00020, 10'd5, 1'b0, 20'h55555, 2'd3, 1'b1, 1'b1);
        load_entry(2, 20'h00030, 10'd6, 1'b0, 20'h66666, 2'd3, 1'b1, 1'b1);
        load_entry(3, 20'h00040, 10'd5, 1'b0, 20'h77777, 2'd3, 1'b1, 1'b0);
        load_entry(4, 20'h00050, 10'd5, 1'b0, 20'h88888, 2'd0, 1'b1, 1'b1);
        load_entry(5, 20'h00060, 10'd5, 1'b0, 20'h0ABCD, 2'd3, 1'b0, 1'b1);

        for (i = 0; i < n_rows; i++) begin
            if (row_da[i] != cfg_da) begin
                // configuration only changes with nothing in flight
                req_valid = 1'b0;
                wait_idle();
                cfg_da   = row_da[i];
                cfg_plv  = 2'd3;
                cfg_asid = 10'd5;
                cfg_dmw0 = 32'h8200_0001;
                cfg_dmw1 = 32'hA000_0008;
            end
            apply_row(i);
        end
        req_valid = 1'b0;

        while (pass_count + fail_count < n_rows) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (pending != 0) begin
            $display("checker queue still holds %0d requests at the end", pending);
            tb_errors = tb_errors + 1;
        end
        if (pass_count + fail_count != n_rows) begin
            $display("got %0d responses for %0d requests", pass_count + fail_count, n_rows);
            tb_errors = tb_errors + 1;
        end

        $display("rows %0d  passed %0d  failed %0d  other errors %0d",
                 n_rows, pass_count, fail_count, tb_errors);
        if (fail_count == 0 && tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/xlate_checker.sv ====
`timescale 1ns/1ps

module xlate_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_ready,
    input  int                            exp_row,
    input  logic [xlate_pkg::addr_w-1:0]  exp_vaddr,
    input  logic                          exp_fault,
    input  logic [xlate_pkg::addr_w-1:0]  exp_word,
    input  logic                          resp_valid,
    input  logic                          resp_ready,
    input  logic                          resp_fault,
    input  xlate_pkg::xlate_result_u      resp_word,
    output int                            pass_count,
    output int                            fail_count,
    output int                            pending
);

    int                            q_row [$];
    logic [xlate_pkg::addr_w-1:0]  q_vaddr [$];
    logic                          q_fault [$];
    logic [xlate_pkg::addr_w-1:0]  q_word [$];

    int                            cur_row;
    logic [xlate_pkg::addr_w-1:0]  cur_vaddr;
    logic                          cur_fault;
    logic [xlate_pkg::addr_w-1:0]  cur_word;

    always @(posedge clk) begin
        if (reset) begin
            q_row.delete();
            q_vaddr.delete();
            q_fault.delete();
            q_word.delete();
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (resp_valid && resp_ready) begin
                if (q_row.size() == 0) begin
                    $display("response at %0d ns arrived with no request outstanding", $time);
                    fail_count = fail_count + 1;
                end else begin
                    cur_row   = q_row.pop_front();
                    cur_vaddr = q_vaddr.pop_front();
                    cur_fault = q_fault.pop_front();
                    cur_word  = q_word.pop_front();
                    if (resp_fault !== cur_fault || resp_word.paddr !== cur_word) begin
                        $display("Fail at %0d ns: row %0d va %h exp %0b %h got %0b %h",
                                 $time, cur_row, cur_vaddr, cur_fault, cur_word,
                                 resp_fault, resp_word.paddr);
                        fail_count = fail_count + 1;
                    end else if (resp_fault) begin
                        $display("row %0d vaddr %h ok, ecode %h",
                                 cur_row, cur_vaddr, resp_word.fault.ecode);
                        pass_count = pass_count + 1;
                    end else begin
                        $display("row %0d vaddr %h ok, paddr %h",
                                 cur_row, cur_vaddr, resp_word.paddr);
                        pass_count = pass_count + 1;
                    end
                end
            end
            // requests are queued in the order the DUT accepts them
            if (req_valid && req_ready) begin
                q_row.push_back(exp_row);
                q_vaddr.push_back(exp_vaddr);
                q_fault.push_back(exp_fault);
                q_word.push_back(exp_word);
            end
        end
        pending = q_row.size();
    end

endmodule

// ==== design/xlate_top.sv ====
`timescale 1ns/1ps

module xlate_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic [xlate_pkg::addr_w-1:0]         req_vaddr,
    input  logic                                 req_store,
    output logic                                 resp_valid,
    input  logic                                 resp_ready,
    output logic                                 resp_fault,
    output xlate_pkg::xlate_result_u             resp_word,
    input  logic                                 cfg_da,
    input  logic [tlb_pkg::plv_w-1:0]            cfg_plv,
    input  logic [tlb_pkg::asid_w-1:0]           cfg_asid,
    input  logic [xlate_pkg::addr_w-1:0]         cfg_dmw0,
    input  logic [xlate_pkg::addr_w-1:0]         cfg_dmw1,
    input  logic                                 tlb_we,
    input  logic [tlb_pkg::tlb_idx_w-1:0]        tlb_windex,
    input  logic                                 tlb_we_e,
    input  logic [tlb_pkg::vpn_w-1:0]            tlb_wvpn,
    input  logic [tlb_pkg::asid_w-1:0]           tlb_wasid,
    input  logic                                 tlb_wg,
    input  logic [tlb_pkg::ppn_w-1:0]            tlb_wppn,
    input  logic [tlb_pkg::plv_w-1:0]            tlb_wplv,
    input  logic                                 tlb_wd,
    input  logic                                 tlb_wv
);

    logic                          cls_valid;
    logic                          cls_ready;
    logic [xlate_pkg::addr_w-1:0]  cls_addr;
    logic                          cls_store;
    logic                          cls_direct;

    logic                          head_valid;
    logic                          head_ready;
    logic [xlate_pkg::addr_w-1:0]  head_addr;
    logic                          head_store;
    logic                          head_direct;

    logic [tlb_pkg::vpn_w-1:0]     s_vpn;
    logic [tlb_pkg::asid_w-1:0]    s_asid;
    logic                          s_found;
    logic [tlb_pkg::ppn_w-1:0]     s_ppn;
    logic [tlb_pkg::plv_w-1:0]     s_plv;
    logic                          s_d;
    logic                          s_v;

    dmw_classify dmw_classify_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_vaddr  (req_vaddr),
        .req_store  (req_store),
        .cfg_da     (cfg_da),
        .cfg_plv    (cfg_plv),
        .cfg_dmw0   (cfg_dmw0),
        .cfg_dmw1   (cfg_dmw1),
        .cls_valid  (cls_valid),
        .cls_ready  (cls_ready),
        .cls_addr   (cls_addr),
        .cls_store  (cls_store),
        .cls_direct (cls_direct)
    );

    req_fifo #(
        .depth (xlate_pkg::fifo_depth)
    ) req_fifo_i (
        .clk         (clk),
        .reset       (reset),
        .cls_valid   (cls_valid),
        .cls_ready   (cls_ready),
        .cls_addr    (cls_addr),
        .cls_store   (cls_store),
        .cls_direct  (cls_direct),
        .head_valid  (head_valid),
        .head_ready  (head_ready),
        .head_addr   (head_addr),
        .head_store  (head_store),
        .head_direct (head_direct)
    );

    tlb_check tlb_check_i (
        .clk         (clk),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_ready  (head_ready),
        .head_addr   (head_addr),
        .head_store  (head_store),
        .head_direct (head_direct),
        .cfg_plv     (cfg_plv),
        .cfg_asid    (cfg_asid),
        .s_vpn       (s_vpn),
        .s_asid      (s_asid),
        .s_found     (s_found),
        .s_ppn       (s_ppn),
        .s_plv       (s_plv),
        .s_d         (s_d),
        .s_v         (s_v),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_fault  (resp_fault),
        .resp_word   (resp_word)
    );

    tlb_array tlb_array_i (
        .clk        (clk),
        .reset      (reset),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_we_e   (tlb_we_e),
        .tlb_wvpn   (tlb_wvpn),
        .tlb_wasid  (tlb_wasid),
        .tlb_wg     (tlb_wg),
        .tlb_wppn   (tlb_wppn),
        .tlb_wplv   (tlb_wplv),
        .tlb_wd     (tlb_wd),
        .tlb_wv     (tlb_wv),
        .s_vpn      (s_vpn),
        .s_asid     (s_asid),
        .s_found    (s_found),
        .s_ppn      (s_ppn),
        .s_plv      (s_plv),
        .s_d        (s_d),
        .s_v        (s_v)
    );

endmodule

// ==== tlb/tlb_check.sv ====
`timescale 1ns/1ps

module tlb_check (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          head_valid,
    output logic                          head_ready,
    input  logic [xlate_pkg::addr_w-1:0]  head_addr,
    input  logic                          head_store,
    input  logic                          head_direct,
    input  logic [tlb_pkg::plv_w-1:0]     cfg_plv,
    input  logic [tlb_pkg::asid_w-1:0]    cfg_asid,
    output logic [tlb_pkg::vpn_w-1:0]     s_vpn,
    output logic [tlb_pkg::asid_w-1:0]    s_asid,
    input  logic                          s_found,
    input  logic [tlb_pkg::ppn_w-1:0]     s_ppn,
    input  logic [tlb_pkg::plv_w-1:0]     s_plv,
    input  logic                          s_d,
    input  logic                          s_v,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic                          resp_fault,
    output xlate_pkg::xlate_result_u      resp_word
);

    logic                              nxt_fault;
    logic [xlate_pkg::ecode_w-1:0]     nxt_code;
    xlate_pkg::xlate_result_u          nxt_word;

    assign s_vpn  = head_addr[xlate_pkg::addr_w-1 -: tlb_pkg::vpn_w];
    assign s_asid = cfg_asid;

    // pop only when the output register frees up this cycle
    assign head_ready = head_valid && (!resp_valid || resp_ready);

    always_comb begin
        nxt_fault = 1'b0;
        nxt_code  = '0;
        if (!head_direct) begin
            if (!s_found) begin
                nxt_fault = 1'b1;
                nxt_code  = xlate_pkg::ecode_tlbr;
            end else if (!s_v) begin
                nxt_fault = 1'b1;
                nxt_code  = head_store ? xlate_pkg::ecode_pis : xlate_pkg::ecode_pil;
            end else if (cfg_plv > s_plv) begin
                nxt_fault = 1'b1;
                nxt_code  = xlate_pkg::ecode_ppi;
            end else if (head_store && !s_d) begin
                nxt_fault = 1'b1;
                nxt_code  = xlate_pkg::ecode_pme;
            end
        end
    end

    always_comb begin
        nxt_word = '0;
        if (nxt_fault) begin
            nxt_word.fault.ecode = nxt_code;
        end else if (head_direct) begin
            nxt_word.paddr = head_addr;
        end else begin
            nxt_word.paddr = {s_ppn, head_addr[tlb_pkg::page_off_w-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (head_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (head_ready) begin
            resp_fault <= nxt_fault;
            resp_word  <= nxt_word;
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready
            |=> resp_valid && $stable(resp_word) && $stable(resp_fault));

endmodule

// ==== tlb/tlb_array.sv ====
`timescale 1ns/1ps

module tlb_array (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          tlb_we,
    input  logic [tlb_pkg::tlb_idx_w-1:0] tlb_windex,
    input  logic                          tlb_we_e,
    input  logic [tlb_pkg::vpn_w-1:0]     tlb_wvpn,
    input  logic [tlb_pkg::asid_w-1:0]    tlb_wasid,
    input  logic                          tlb_wg,
    input  logic [tlb_pkg::ppn_w-1:0]     tlb_wppn,
    input  logic [tlb_pkg::plv_w-1:0]     tlb_wplv,
    input  logic                          tlb_wd,
    input  logic                          tlb_wv,
    input  logic [tlb_pkg::vpn_w-1:0]     s_vpn,
    input  logic [tlb_pkg::asid_w-1:0]    s_asid,
    output logic                          s_found,
    output logic [tlb_pkg::ppn_w-1:0]     s_ppn,
    output logic [tlb_pkg::plv_w-1:0]     s_plv,
    output logic                          s_d,
    output logic                          s_v
);

    logic [tlb_pkg::tlb_entries-1:0]  e;
    logic [tlb_pkg::vpn_w-1:0]        vpn  [tlb_pkg::tlb_entries];
    logic [tlb_pkg::asid_w-1:0]       asid [tlb_pkg::tlb_entries];
    logic                             g    [tlb_pkg::tlb_entries];
    logic [tlb_pkg::ppn_w-1:0]        ppn  [tlb_pkg::tlb_entries];
    logic [tlb_pkg::plv_w-1:0]        plv  [tlb_pkg::tlb_entries];
    logic                             d    [tlb_pkg::tlb_entries];
    logic                             v    [tlb_pkg::tlb_entries];
    logic [tlb_pkg::tlb_idx_w-1:0]    hit_idx;

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            e <= '0;
        end else if (tlb_we) begin
            e[tlb_windex] <= tlb_we_e;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vpn[tlb_windex]  <= tlb_wvpn;
            asid[tlb_windex] <= tlb_wasid;
            g[tlb_windex]    <= tlb_wg;
            ppn[tlb_windex]  <= tlb_wppn;
            plv[tlb_windex]  <= tlb_wplv;
            d[tlb_windex]    <= tlb_wd;
            v[tlb_windex]    <= tlb_wv;
        end
    end

    // scan downwards so the lowest matching index wins
    always_comb begin
        s_found = 1'b0;
        hit_idx = '0;
        for (int i = tlb_pkg::tlb_entries - 1; i >= 0; i--) begin
            if (e[i] && (vpn[i] == s_vpn) && (g[i] || (asid[i] == s_asid))) begin
                s_found = 1'b1;
                hit_idx = i[tlb_pkg::tlb_idx_w-1:0];
            end
        end
    end

    assign s_ppn = ppn[hit_idx];
    assign s_plv = plv[hit_idx];
    assign s_d   = d[hit_idx];
    assign s_v   = v[hit_idx];

endmodule

// ==== design/req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
    parameter int depth = xlate_pkg::fifo_depth
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cls_valid,
    output logic                          cls_ready,
    input  logic [xlate_pkg::addr_w-1:0]  cls_addr,
    input  logic                          cls_store,
    input  logic                          cls_direct,
    output logic                          head_valid,
    input  logic                          head_ready,
    output logic [xlate_pkg::addr_w-1:0]  head_addr,
    output logic                          head_store,
    output logic                          head_direct
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [xlate_pkg::addr_w-1:0]  mem_addr [depth];
    logic                          mem_store [depth];
    logic                          mem_direct [depth];
    logic [ptr_w-1:0]              wr_ptr;
    logic [ptr_w-1:0]              rd_ptr;
    logic [cnt_w-1:0]              count;
    logic                          push;
    logic                          pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign cls_ready  = (count != cnt_w'(depth));
    assign head_valid = (count != '0);
    assign push       = cls_valid && cls_ready;
    assign pop        = head_ready;

    assign head_addr   = mem_addr[rd_ptr];
    assign head_store  = mem_store[rd_ptr];
    assign head_direct = mem_direct[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_addr[wr_ptr]   <= cls_addr;
            mem_store[wr_ptr]  <= cls_store;
            mem_direct[wr_ptr] <= cls_direct;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leaves count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count <= cnt_w'(depth));

    // consumer must only pop a visible head
    a_no_empty_pop: assert property (@(posedge clk) disable iff (reset)
        head_ready |-> head_valid);

endmodule

// ==== design/dmw_classify.sv ====
`timescale 1ns/1ps

module dmw_classify (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [xlate_pkg::addr_w-1:0]  req_vaddr,
    input  logic                          req_store,
    input  logic                          cfg_da,
    input  logic [tlb_pkg::plv_w-1:0]     cfg_plv,
    input  logic [xlate_pkg::addr_w-1:0]  cfg_dmw0,
    input  logic [xlate_pkg::addr_w-1:0]  cfg_dmw1,
    output logic                          cls_valid,
    input  logic                          cls_ready,
    output logic [xlate_pkg::addr_w-1:0]  cls_addr,
    output logic                          cls_store,
    output logic                          cls_direct
);

    logic                          hit0;
    logic                          hit1;
    logic [xlate_pkg::addr_w-1:0]  nxt_addr;
    logic                          nxt_direct;

    // segment compare plus the enable bit for the current plv
    function automatic logic win_hit(input logic [xlate_pkg::addr_w-1:0] dmw,
                                     input logic [xlate_pkg::addr_w-1:0] va,
                                     input logic [tlb_pkg::plv_w-1:0]    plv);
        logic [xlate_pkg::seg_w-1:0] vseg;
        vseg = dmw[xlate_pkg::dmw_vseg_lsb +: xlate_pkg::seg_w];
        return (va[xlate_pkg::addr_w-1 -: xlate_pkg::seg_w] == vseg)
            && dmw[xlate_pkg::dmw_plv0_bit + plv];
    endfunction

    assign hit0 = win_hit(cfg_dmw0, req_vaddr, cfg_plv);
    assign hit1 = win_hit(cfg_dmw1, req_vaddr, cfg_plv);

    always_comb begin
        nxt_addr   = req_vaddr;
        nxt_direct = 1'b1;
        if (cfg_da) begin
            nxt_addr = req_vaddr;
        end else if (hit0) begin
            nxt_addr[xlate_pkg::addr_w-1 -: xlate_pkg::seg_w] =
                cfg_dmw0[xlate_pkg::dmw_pseg_lsb +: xlate_pkg::seg_w];
        end else if (hit1) begin
            nxt_addr[xlate_pkg::addr_w-1 -: xlate_pkg::seg_w] =
                cfg_dmw1[xlate_pkg::dmw_pseg_lsb +: xlate_pkg::seg_w];
        end else begin
            // left for the tlb
            nxt_direct = 1'b0;
        end
    end

    assign req_ready = !cls_valid || cls_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            cls_valid <= 1'b0;
        end else if (req_ready) begin
            cls_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cls_addr   <= nxt_addr;
            cls_store  <= req_store;
            cls_direct <= nxt_direct;
        end
    end

    a_cls_hold: assert property (@(posedge clk) disable iff (reset)
        cls_valid && !cls_ready |=> cls_valid && $stable(cls_addr) && $stable(cls_direct));

endmodule

// ==== common/tlb_pkg.sv ====
package tlb_pkg;

    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = 4;

    // one 4 KB page per entry
    localparam int vpn_w      = 20;
    localparam int ppn_w      = 20;
    localparam int page_off_w = 12;

    localparam int asid_w = 10;
    localparam int plv_w  = 2;

endpackage

// ==== common/xlate_pkg.sv ====
package xlate_pkg;

    localparam int addr_w = 32;
    localparam int seg_w  = 3;
    localparam int ecode_w = 6;

    // dmw word layout
    localparam int dmw_plv0_bit = 0;
    localparam int dmw_pseg_lsb = 25;
    localparam int dmw_vseg_lsb = 29;

    localparam logic [ecode_w-1:0] ecode_tlbr = 6'h3F;
    localparam logic [ecode_w-1:0] ecode_pil  = 6'h01;
    localparam logic [ecode_w-1:0] ecode_pis  = 6'h02;
    localparam logic [ecode_w-1:0] ecode_pme  = 6'h04;
    localparam logic [ecode_w-1:0] ecode_ppi  = 6'h07;

    localparam int fifo_depth = 4;

    // response word read as paddr on success or as a fault record
    typedef union packed {
        logic [addr_w-1:0] paddr;
        struct packed {
            logic [ecode_w-1:0]        ecode;
            logic [addr_w-ecode_w-1:0] pad;
        } fault;
    } xlate_result_u;

endpackage
